// File: include/alu_settings.svh
/* Execute unit settings
   Word size, register file size and the AXI4-Lite address map */

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

////////////////////////////////////////
// Datapath

`define ALU_DATA_W 32   // Operand and register width
`define ALU_REG_N 32    // Register count, 5-bit index
`define ALU_CNT_W 16    // Completed instruction counter in status

////////////////////////////////////////
// AXI4-Lite map, byte addresses

`define ALU_AXI_ADDR_W 8
`define ALU_ADDR_INSTR 8'h00    // Instruction word
`define ALU_ADDR_STATUS 8'h04   // Flags and count
`define ALU_ADDR_REG_BASE 8'h80 // Registers 0..31 at 0x80..0xFC

`endif

// File: design/alu_pkg.sv
/* Execute unit types
   Operation codes, issued instruction and ALU flags */

`include "alu_settings.svh"

package alu_pkg;

  // Register index, 5 bits for 32 registers
  typedef logic [$clog2(`ALU_REG_N)-1:0] reg_idx_t;

  // Operation codes, MIPS ALU control values
  typedef enum logic [3:0]
  {
    OP_AND  = 4'h0,
    OP_OR   = 4'h1,
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h6,
    OP_SLT  = 4'h7,   // Signed set-less-than
    OP_NOR  = 4'hC,
    OP_LOAD = 4'hF    // Internal, writes imm to rd
  } alu_op_t;

  // One issued instruction
  typedef struct packed
  {
    alu_op_t                 op;
    reg_idx_t                rd;
    reg_idx_t                rs;
    reg_idx_t                rt;
    logic [`ALU_DATA_W-1:0]  imm;  // Load value only
  } alu_instr_t;

  // Flags of one result, status bits 2:0
  typedef struct packed
  {
    logic carry;     // Bit 2
    logic zero;      // Bit 1
    logic overflow;  // Bit 0
  } alu_flags_t;

endpackage

// File: design/issue_if.sv
/* Instruction issue link
   Host port hands one instruction per valid pulse to the pipeline */

`timescale 1ns/10ps

interface issue_if
  import alu_pkg::*;
();

  logic       valid;  // One cycle per instruction, always taken
  alu_instr_t instr;
  logic       idle;   // No stage holds an instruction

  // Host side, AXI port
  modport host
  (
    output valid,
    output instr,
    input  idle
  );

  // Pipeline side
  modport pipe
  (
    input  valid,
    input  instr,
    output idle
  );

endinterface

// File: design/axil_cmd_port.sv
/* AXI4-Lite command port
   Writes become instructions or loads, reads return registers or status */

`timescale 1ns/10ps

`include "alu_settings.svh"

module axil_cmd_port
  import alu_pkg::*;
(
  input  logic                          clock,
  input  logic                          reset,
  // Write address and data
  input  logic [`ALU_AXI_ADDR_W-1:0]    awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`ALU_DATA_W-1:0]        wdata,
  input  logic [`ALU_DATA_W/8-1:0]      wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  // Write response
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  // Read address and data
  input  logic [`ALU_AXI_ADDR_W-1:0]    araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`ALU_DATA_W-1:0]        rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,
  // Pipeline side
  issue_if.host                         issue,
  output reg_idx_t                      host_raddr,
  input  logic [`ALU_DATA_W-1:0]        host_rdata,
  input  logic [`ALU_DATA_W-1:0]        status
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic       wr_fire;       // AW and W handshake together
  logic       rd_fire;
  logic       aw_is_instr;
  logic       aw_is_reg;
  logic       strb_full;
  logic       op_ok;
  logic       wr_ok;
  alu_instr_t wr_instr;
  logic       ar_is_status;
  logic       ar_is_reg;

  ////////////////////////////////////////
  // Write decode

  // Both channels taken at once, only with no B pending
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign wr_fire = awready && wready;

  assign aw_is_instr = (awaddr == `ALU_ADDR_INSTR);
  // Base is a single bit, so it doubles as the range mask
  assign aw_is_reg   = ((awaddr & `ALU_ADDR_REG_BASE) == `ALU_ADDR_REG_BASE) &&
                       (awaddr[1:0] == 2'b00);
  assign strb_full   = &wstrb;  // Partial words rejected

  always_comb
  begin
    case (wdata[3:0])
      OP_AND, OP_OR, OP_ADD, OP_SUB,
      OP_SLT, OP_NOR, OP_LOAD: op_ok = 1'b1;
      default:                 op_ok = 1'b0;
    endcase
  end

  assign wr_ok = strb_full && (aw_is_reg || (aw_is_instr && op_ok));

  // Instruction word fields, or a load for a register address
  always_comb
  begin
    wr_instr = '0;
    if (aw_is_reg)
    begin
      wr_instr.op  = OP_LOAD;
      wr_instr.rd  = awaddr[6:2];   // Word index within the register window
      wr_instr.imm = wdata;
    end
    else
    begin
      wr_instr.op = alu_op_t'(wdata[3:0]);
      wr_instr.rd = wdata[8:4];
      wr_instr.rs = wdata[13:9];
      wr_instr.rt = wdata[18:14];   // Load via the word clears rd, imm is zero
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      issue.valid <= 1'b0;
      bvalid      <= 1'b0;
    end
    else
    begin
      issue.valid <= wr_fire && wr_ok;  // Single cycle pulse
      if (wr_fire)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (wr_fire)
    begin
      bresp       <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      issue.instr <= wr_instr;
    end
  end

  ////////////////////////////////////////
  // Read decode

  // Wait for an empty pipeline so earlier writes are visible
  assign arready    = arvalid && issue.idle && !rvalid;
  assign rd_fire    = arready;
  assign host_raddr = araddr[6:2];

  assign ar_is_status = (araddr == `ALU_ADDR_STATUS);
  assign ar_is_reg    = ((araddr & `ALU_ADDR_REG_BASE) == `ALU_ADDR_REG_BASE) &&
                        (araddr[1:0] == 2'b00);

  always_ff @(posedge clock)
  begin
    if (reset)
      rvalid <= 1'b0;
    else if (rd_fire)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  // Data held while rvalid waits on rready
  always_ff @(posedge clock)
  begin
    if (rd_fire)
    begin
      rresp <= (ar_is_status || ar_is_reg) ? RESP_OKAY : RESP_SLVERR;
      if (ar_is_status)
        rdata <= status;
      else if (ar_is_reg)
        rdata <= host_rdata;
      else
        rdata <= '0;
    end
  end

  // B response held under back-pressure
  a_bresp_hold: assert property (@(posedge clock) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp));

  // Issue is a pulse, the pipeline never stalls it
  a_issue_pulse: assert property (@(posedge clock) disable iff (reset)
    issue.valid |=> !issue.valid);

endmodule

// File: design/reg_file.sv
/* Register file, 32 words
   Two pipeline read ports, one host read port, one write port, r0 is zero */

`timescale 1ns/10ps

`include "alu_settings.svh"

module reg_file
  import alu_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  reg_idx_t                  ra_idx,   // rs
  input  reg_idx_t                  rb_idx,   // rt
  input  reg_idx_t                  rh_idx,   // Host
  output logic [`ALU_DATA_W-1:0]    ra_data,
  output logic [`ALU_DATA_W-1:0]    rb_data,
  output logic [`ALU_DATA_W-1:0]    rh_data,
  input  logic                      we,
  input  reg_idx_t                  wr_idx,
  input  logic [`ALU_DATA_W-1:0]    wr_data
);

  logic [`ALU_DATA_W-1:0] regs [`ALU_REG_N];

  // Synchronous write, r0 never written
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < `ALU_REG_N; i++)
        regs[i] <= '0;
    end
    else if (we && (wr_idx != '0))
    begin
      regs[wr_idx] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // Combinational reads

  // r0 forced to zero on every port
  assign ra_data = (ra_idx == '0) ? '0 : regs[ra_idx];
  assign rb_data = (rb_idx == '0) ? '0 : regs[rb_idx];
  assign rh_data = (rh_idx == '0) ? '0 : regs[rh_idx];

endmodule

// File: design/alu_32.sv
/* 32-bit ALU
   and, or, add, sub, slt, nor and the load pass-through, with flags */

`timescale 1ns/10ps

`include "alu_settings.svh"

module alu_32
  import alu_pkg::*;
(
  input  alu_op_t                   op,
  input  logic [`ALU_DATA_W-1:0]    a,
  input  logic [`ALU_DATA_W-1:0]    b,
  input  logic [`ALU_DATA_W-1:0]    imm,
  output logic [`ALU_DATA_W-1:0]    result,
  output alu_flags_t                flags
);

  logic                       is_sub;
  logic                       is_arith;  // add or sub
  logic [`ALU_DATA_W-1:0]     b_eff;
  logic [`ALU_DATA_W:0]       sum;       // Top bit is carry out

  ////////////////////////////////////////
  // Shared adder

  assign is_sub   = (op == OP_SUB);
  assign is_arith = (op == OP_ADD) || is_sub;

  // Subtract as a + ~b + 1
  assign b_eff = is_sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{`ALU_DATA_W{1'b0}}, is_sub};

  always_comb
  begin
    case (op)
      OP_AND:         result = a & b;
      OP_OR:          result = a | b;
      OP_ADD, OP_SUB: result = sum[`ALU_DATA_W-1:0];
      OP_SLT:         result = {{(`ALU_DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
      OP_NOR:         result = ~(a | b);
      OP_LOAD:        result = imm;       // Immediate straight through
      default:        result = '0;
    endcase
  end

  ////////////////////////////////////////
  // Flags

  assign flags.zero  = (result == '0);
  // For sub, carry set means no borrow
  assign flags.carry = is_arith && sum[`ALU_DATA_W];
  // Same-sign operands, result sign differs
  assign flags.overflow = is_arith &&
                          (a[`ALU_DATA_W-1] == b_eff[`ALU_DATA_W-1]) &&
                          (sum[`ALU_DATA_W-1] != a[`ALU_DATA_W-1]);

endmodule

// File: design/exec_pipeline.sv
/* Three stage execute pipeline
   Register read, ALU execute and writeback, with forwarding and status */

`timescale 1ns/10ps

`include "alu_settings.svh"

module exec_pipeline
  import alu_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  issue_if.pipe                     issue,
  input  reg_idx_t                  host_raddr,
  output logic [`ALU_DATA_W-1:0]    host_rdata,
  output logic [`ALU_DATA_W-1:0]    status
);

  logic [`ALU_DATA_W-1:0] ra_data, rb_data;   // Register file outputs
  logic [`ALU_DATA_W-1:0] fwd_a, fwd_b;       // After forwarding
  logic                   ex_hit_a, ex_hit_b, wb_hit_a, wb_hit_b;
  // Execute stage
  logic                   ex_valid;
  alu_op_t                ex_op;
  reg_idx_t               ex_rd;
  logic [`ALU_DATA_W-1:0] ex_a, ex_b, ex_imm;
  logic [`ALU_DATA_W-1:0] alu_result;
  alu_flags_t             alu_flags;
  // Writeback stage
  logic                   wb_valid;
  reg_idx_t               wb_rd;
  logic [`ALU_DATA_W-1:0] wb_result;
  alu_flags_t             wb_flags;
  // Status
  alu_flags_t             flags_q;
  logic [`ALU_CNT_W-1:0]  count_q;

  reg_file i_reg_file
  (
    .clock   (clock),
    .reset   (reset),
    .ra_idx  (issue.instr.rs),
    .rb_idx  (issue.instr.rt),
    .rh_idx  (host_raddr),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .rh_data (host_rdata),
    .we      (wb_valid),
    .wr_idx  (wb_rd),
    .wr_data (wb_result)
  );

  ////////////////////////////////////////
  // Read stage, fed by the issue pulse

  // Newest result wins, r0 never forwarded
  assign ex_hit_a = ex_valid && (ex_rd != '0) && (ex_rd == issue.instr.rs);
  assign ex_hit_b = ex_valid && (ex_rd != '0) && (ex_rd == issue.instr.rt);
  assign wb_hit_a = wb_valid && (wb_rd != '0) && (wb_rd == issue.instr.rs);
  assign wb_hit_b = wb_valid && (wb_rd != '0) && (wb_rd == issue.instr.rt);

  assign fwd_a = ex_hit_a ? alu_result : (wb_hit_a ? wb_result : ra_data);
  assign fwd_b = ex_hit_b ? alu_result : (wb_hit_b ? wb_result : rb_data);

  ////////////////////////////////////////
  // Execute and writeback stages

  alu_32 i_alu
  (
    .op     (ex_op),
    .a      (ex_a),
    .b      (ex_b),
    .imm    (ex_imm),
    .result (alu_result),
    .flags  (alu_flags)
  );

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
      flags_q  <= '0;
      count_q  <= '0;
    end
    else
    begin
      ex_valid <= issue.valid;
      wb_valid <= ex_valid;
      if (wb_valid)
      begin
        flags_q <= wb_flags;          // Last completed instruction
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Stage payloads
  always_ff @(posedge clock)
  begin
    ex_op     <= issue.instr.op;
    ex_rd     <= issue.instr.rd;
    ex_a      <= fwd_a;
    ex_b      <= fwd_b;
    ex_imm    <= issue.instr.imm;
    wb_rd     <= ex_rd;
    wb_result <= alu_result;
    wb_flags  <= alu_flags;
  end

  assign issue.idle = !(issue.valid || ex_valid || wb_valid);
  assign status     = {count_q, {(`ALU_DATA_W-`ALU_CNT_W-3){1'b0}}, flags_q};

  // Nothing retires while idle, so host reads see settled status
  a_idle_settled: assert property (@(posedge clock) disable iff (reset)
    issue.idle |=> $stable(status));

endmodule

// File: design/alu_subsystem.sv
/* Execute unit top level
   AXI4-Lite command port driving the three stage pipeline */

`timescale 1ns/10ps

`include "alu_settings.svh"

module alu_subsystem
  import alu_pkg::*;
(
  input  logic                          clock,
  input  logic                          reset,
  input  logic [`ALU_AXI_ADDR_W-1:0]    awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`ALU_DATA_W-1:0]        wdata,
  input  logic [`ALU_DATA_W/8-1:0]      wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [`ALU_AXI_ADDR_W-1:0]    araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`ALU_DATA_W-1:0]        rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready
);

  reg_idx_t               host_raddr;   // Host register read path
  logic [`ALU_DATA_W-1:0] host_rdata;
  logic [`ALU_DATA_W-1:0] status;

  issue_if issue ();

  axil_cmd_port i_cmd_port
  (
    .clock      (clock),
    .reset      (reset),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .issue      (issue),
    .host_raddr (host_raddr),
    .host_rdata (host_rdata),
    .status     (status)
  );

  exec_pipeline i_pipeline
  (
    .clock      (clock),
    .reset      (reset),
    .issue      (issue),
    .host_raddr (host_raddr),
    .host_rdata (host_rdata),
    .status     (status)
  );

endmodule

// File: tb/tb_clock_gen.sv
/* Testbench clock and reset
   40 ns clock, synchronous reset held over two rising edges */

`timescale 1ns/10ps

module tb_clock_gen
(
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;  // 40 ns period
  end

  // Released on a falling edge, away from the sampling edge
  initial
  begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// File: tb/tb_alu_subsystem.sv
/* Execute unit testbench
   Drives alu_subsystem over AXI4-Lite and checks it against a reference model */

`timescale 1ns/10ps

`include "alu_settings.svh"

module tb_alu_subsystem
  import alu_pkg::*;
();

  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;
  localparam int CYCLE_LIMIT    = 20000;  // About ten times the run length

  logic                         clock;
  logic                         reset;
  logic [`ALU_AXI_ADDR_W-1:0]   awaddr, araddr;
  logic                         awvalid, wvalid, bready, arvalid, rready;
  logic                         awready, wready, bvalid, arready, rvalid;
  logic [`ALU_DATA_W-1:0]       wdata, rdata;
  logic [`ALU_DATA_W/8-1:0]     wstrb;
  logic [1:0]                   bresp, rresp;

  // Reference state
  logic [`ALU_DATA_W-1:0] ref_regs [`ALU_REG_N];
  logic [2:0]             ref_flags;      // carry, zero, overflow
  logic [15:0]            ref_count;      // Wraps like the status field
  logic [31:0]            rng_state;
  int unsigned            cycle_count = 0;

  tb_clock_gen i_clock_gen (.clock(clock), .reset(reset));

  alu_subsystem i_dut
  (
    .clock(clock), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  // Run limit
  always @(posedge clock)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("TEST FAIL");
      $fatal(1, "Timeout");
    end
  end

  ////////////////////////////////////////
  // Random numbers and reference model

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Returns {carry, zero, overflow, result}
  function automatic logic [34:0] ref_exec(input alu_op_t op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] imm);
    logic [31:0]        r;
    logic               c;
    logic               v;
    logic signed [32:0] wide;   // Exact signed result
    c = 1'b0;
    v = 1'b0;
    case (op)
      OP_AND: r = a & b;
      OP_OR:  r = a | b;
      OP_ADD:
      begin
        {c, r} = {1'b0, a} + {1'b0, b};
        wide   = $signed({a[31], a}) + $signed({b[31], b});
        v      = (wide[32] != wide[31]);   // Outside the 32-bit signed range
      end
      OP_SUB:
      begin
        r    = a - b;
        c    = (a >= b);    // Set when no borrow
        wide = $signed({a[31], a}) - $signed({b[31], b});
        v    = (wide[32] != wide[31]);
      end
      OP_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_NOR: r = ~(a | b);
      default: r = imm;  // Load
    endcase
    return {c, (r == 32'd0), v, r};
  endfunction

  // One completed instruction
  function automatic void apply_model(input alu_op_t op, input logic [4:0] rd,
                                      input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [31:0] imm);
    logic [34:0] res;
    res = ref_exec(op, ref_regs[rs], ref_regs[rt], imm);
    if (rd != 5'd0)
      ref_regs[rd] = res[31:0];  // r0 stays zero
    ref_flags = res[34:32];
    ref_count = ref_count + 16'd1;
  endfunction

  function automatic logic [31:0] expected_status();
    return {ref_count, 13'd0, ref_flags};
  endfunction

  function automatic logic [7:0] reg_addr(input logic [4:0] idx);
    return {1'b1, idx, 2'b00};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %08h actual %08h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  ////////////////////////////////////////
  // AXI4-Lite driver

  task automatic write_axil(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strobe, input bit hold_b,
                            output logic [1:0] resp);
    int unsigned hold;
    hold = hold_b ? (next_rand() % 8) + 1 : 0;
    @(negedge clock);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strobe;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = !hold_b;
    do
      @(posedge clock);
    while (!awready);      // Both channels taken together
    check_eq("wready with awready", 1, wready);
    @(negedge clock);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    do
      @(posedge clock);
    while (!bvalid);
    resp = bresp;
    if (hold_b)
    begin
      repeat (hold)
      begin
        @(posedge clock);
        check_eq("b hold bvalid", 1, bvalid);
        check_eq("b hold bresp", resp, bresp);
      end
      @(negedge clock);
      bready = 1'b1;
      @(posedge clock);
      check_eq("b final bvalid", 1, bvalid);
    end
  endtask

  task automatic read_axil(input logic [7:0] addr, input bit hold_r,
                           output logic [31:0] data, output logic [1:0] resp);
    int unsigned hold;
    hold = hold_r ? (next_rand() % 8) + 1 : 0;
    @(negedge clock);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = !hold_r;
    do
      @(posedge clock);
    while (!arready);      // Waits for an idle pipeline
    @(negedge clock);
    arvalid = 1'b0;
    do
      @(posedge clock);
    while (!rvalid);
    data = rdata;
    resp = rresp;
    if (hold_r)
    begin
      repeat (hold)
      begin
        @(posedge clock);
        check_eq("r hold rvalid", 1, rvalid);
        check_eq("r hold rdata", data, rdata);
        check_eq("r hold rresp", resp, rresp);
      end
      @(negedge clock);
      rready = 1'b1;
      @(posedge clock);
      check_eq("r final rvalid", 1, rvalid);
    end
  endtask

  ////////////////////////////////////////
  // Higher level steps

  task automatic issue_instr(input alu_op_t op, input logic [4:0] rd, input logic [4:0] rs,
                             input logic [4:0] rt, input bit hold_b);
    logic [1:0] resp;
    write_axil(`ALU_ADDR_INSTR, {13'd0, rt, rs, rd, op}, 4'hF, hold_b, resp);
    check_eq("instr bresp", OKAY, resp);
    apply_model(op, rd, rs, rt, 32'd0);
  endtask

  task automatic load_reg(input logic [4:0] idx, input logic [31:0] value, input bit hold_b);
    logic [1:0] resp;
    write_axil(reg_addr(idx), value, 4'hF, hold_b, resp);
    check_eq("load bresp", OKAY, resp);
    apply_model(OP_LOAD, idx, 5'd0, 5'd0, value);
  endtask

  task automatic read_check(input string name, input logic [7:0] addr,
                            input logic [31:0] expected, input bit hold_r);
    logic [31:0] data;
    logic [1:0]  resp;
    read_axil(addr, hold_r, data, resp);
    check_eq({name, " rresp"}, OKAY, resp);
    check_eq(name, expected, data);
  endtask

  // Every register, then status
  task automatic check_all(input bit hold_r);
    for (int i = 0; i < `ALU_REG_N; i++)
      read_check($sformatf("r%0d", i), reg_addr(5'(i)), ref_regs[i], hold_r);
    read_check("status", `ALU_ADDR_STATUS, expected_status(), hold_r);
  endtask

  task automatic expect_slverr(input string name, input logic [7:0] addr,
                               input logic [31:0] data, input logic [3:0] strobe);
    logic [1:0] resp;
    write_axil(addr, data, strobe, 1'b0, resp);
    check_eq(name, SLVERR, resp);
  endtask

  ////////////////////////////////////////
  // Stimulus

  initial
  begin
    alu_op_t     ops [6];
    logic [4:0]  rd, rs, rt;
    logic [31:0] data;
    logic [1:0]  resp;

    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    rng_state = 32'he403_f4f7;
    ops = '{OP_AND, OP_OR, OP_ADD, OP_SUB, OP_SLT, OP_NOR};
    for (int i = 0; i < `ALU_REG_N; i++)
      ref_regs[i] = '0;
    ref_flags = '0;
    ref_count = '0;

    while (reset !== 1'b0)
      @(negedge clock);

    // Quiet bus after reset
    repeat (4)
    begin
      @(posedge clock);
      check_eq("idle bvalid", 0, bvalid);
      check_eq("idle rvalid", 0, rvalid);
      check_eq("idle awready", 0, awready);
      check_eq("idle wready", 0, wready);
      check_eq("idle arready", 0, arready);
    end
    check_all(1'b0);

    // Loads and readback, r0 included
    for (int i = 0; i < `ALU_REG_N; i++)
      load_reg(5'(i), next_rand(), 1'b0);
    check_all(1'b0);

    // Random instructions, each checked at rd and status
    for (int n = 0; n < 200; n++)
    begin
      if (n % 8 == 0)
        load_reg(5'(next_rand()), next_rand(), 1'b0);  // Fresh operand now and then
      rd = 5'(next_rand());
      rs = 5'(next_rand());
      rt = 5'(next_rand());
      issue_instr(ops[next_rand() % 6], rd, rs, rt, 1'b0);
      read_check($sformatf("rand r%0d", rd), reg_addr(rd), ref_regs[rd], 1'b0);
      read_check("rand status", `ALU_ADDR_STATUS, expected_status(), 1'b0);
    end

    // Countdown, writes back to back
    load_reg(5'd1, 32'd1, 1'b0);
    load_reg(5'd2, 32'd3, 1'b0);
    load_reg(5'd3, 32'd6, 1'b0);
    load_reg(5'd4, 32'd0, 1'b0);
    for (int k = 0; k < 7; k++)
    begin
      issue_instr(OP_ADD, 5'd4, 5'd4, 5'd2, 1'b0);  // r4 += r2
      issue_instr(OP_SUB, 5'd3, 5'd3, 5'd1, 1'b0);  // r3 -= r1
      issue_instr(OP_SLT, 5'd5, 5'd0, 5'd3, 1'b0);  // r5 = 0 < r3, needs r3 at once
      issue_instr(OP_ADD, 5'd6, 5'd5, 5'd4, 1'b0);  // Chains on r5
    end
    check_all(1'b0);

    // Rejected requests leave state alone
    expect_slverr("bad op", `ALU_ADDR_INSTR, {13'd0, 5'd3, 5'd2, 5'd1, 4'h5}, 4'hF);
    expect_slverr("bad op A", `ALU_ADDR_INSTR, {13'd0, 5'd3, 5'd2, 5'd7, 4'hA}, 4'hF);
    expect_slverr("unmapped 08", 8'h08, 32'h1234_5678, 4'hF);
    expect_slverr("status write", `ALU_ADDR_STATUS, 32'hFFFF_FFFF, 4'hF);
    expect_slverr("unaligned reg", 8'h86, 32'hDEAD_BEEF, 4'hF);
    expect_slverr("partial load", reg_addr(5'd9), 32'hCAFE_F00D, 4'h7);
    expect_slverr("partial instr", `ALU_ADDR_INSTR, {13'd0, 5'd3, 5'd2, 5'd1, 4'h2}, 4'h3);
    read_axil(8'h0C, 1'b0, data, resp);
    check_eq("unmapped read rresp", SLVERR, resp);
    check_eq("unmapped read rdata", 0, data);
    check_all(1'b0);

    // Held responses
    for (int n = 0; n < 40; n++)
    begin
      rd = 5'(next_rand());
      rs = 5'(next_rand());
      rt = 5'(next_rand());
      if (next_rand() % 3 == 0)
        load_reg(rd, next_rand(), 1'b1);
      else
        issue_instr(ops[next_rand() % 6], rd, rs, rt, 1'b1);
      read_check($sformatf("bp r%0d", rd), reg_addr(rd), ref_regs[rd], 1'b1);
    end
    check_all(1'b1);

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
design/alu_pkg.sv
design/issue_if.sv
design/axil_cmd_port.sv
design/reg_file.sv
design/alu_32.sv
design/exec_pipeline.sv
design/alu_subsystem.sv
tb/tb_clock_gen.sv
tb/tb_alu_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build the execute unit testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module tb_alu_subsystem -Mdir obj_dir -o sim_alu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_alu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
